/* mem_defines.svh */
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// words per cache line, one cbus refill burst
`define LINE_WORDS 4

// direct-mapped index width, 16 lines
`define INDEX_BITS 4

// segment decode on the top three address bits
`define SEG_MASK   32'hE000_0000
`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'hA000_0000

`endif

/* mem_pkg.sv */
`include "mem_defines.svh"

package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strobe_t;

    // beat count minus one
    typedef logic [3:0] burst_len_t;

    typedef logic [`INDEX_BITS-1:0] index_t;

    // what is left above index and line offset
    typedef logic [31-`INDEX_BITS-$clog2(`LINE_WORDS)-2:0] tag_t;

    typedef enum logic [2:0] {
        CACHE_IDLE,
        CACHE_LOOKUP,
        CACHE_REFILL,
        CACHE_WRITE_BUS,
        CACHE_RESPOND
    } cache_state_t;

    typedef enum logic [1:0] {
        BRIDGE_IDLE,
        BRIDGE_BUS,
        BRIDGE_RESPOND
    } bridge_state_t;

endpackage

/* bus_if.sv */
`timescale 1ns/1ps

// processor side data path, valid / addr_ok / data_ok
interface dbus_if import mem_pkg::*; ();
    logic valid;
    addr_t addr;
    strobe_t strobe;
    word_t wdata;
    logic addr_ok;
    logic data_ok;
    word_t rdata;

    modport master (
        output valid, addr, strobe, wdata,
        input addr_ok, data_ok, rdata
    );

    modport slave (
        input valid, addr, strobe, wdata,
        output addr_ok, data_ok, rdata
    );
endinterface

// cache bus, valid / ready / last
interface cbus_if import mem_pkg::*; ();
    logic valid;
    logic is_write;
    addr_t addr;
    burst_len_t len;
    word_t wdata;
    strobe_t strobe;
    logic ready;
    logic last;
    word_t rdata;

    modport master (
        output valid, is_write, addr, len, wdata, strobe,
        input ready, last, rdata
    );

    modport slave (
        input valid, is_write, addr, len, wdata, strobe,
        output ready, last, rdata
    );
endinterface

/* addr_translate.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module addr_translate import mem_pkg::*; (
    input addr_t vaddr,
    output addr_t paddr,
    output logic uncached
);

    logic in_kseg0;
    logic in_kseg1;
    logic unmapped;

    // kseg0 and kseg1 alias the low 512 MB
    assign in_kseg0 = (vaddr & `SEG_MASK) == `KSEG0_BASE;
    assign in_kseg1 = (vaddr & `SEG_MASK) == `KSEG1_BASE;
    assign unmapped = in_kseg0 || in_kseg1;

    // everything else is one to one
    assign paddr = unmapped ? (vaddr & ~`SEG_MASK) : vaddr;

    // kseg0 always cached, no config attribute
    assign uncached = in_kseg1;

endmodule

/* line_cache.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module line_cache import mem_pkg::*; #(
    parameter bit WRITE_THROUGH = 1'b1
) (
    input logic clk,
    input logic rst,
    dbus_if.slave req,
    cbus_if.master mem
);

    localparam int LINES = 1 << `INDEX_BITS;
    localparam int WORD_BITS = $clog2(`LINE_WORDS);
    localparam int OFFSET_BITS = WORD_BITS + 2;
    localparam int TAG_LSB = OFFSET_BITS + `INDEX_BITS;

    cache_state_t state_q;
    addr_t addr_q;
    strobe_t strobe_q;
    word_t wdata_q;
    logic [WORD_BITS-1:0] beat_q;
    logic pending_q;

    logic [LINES-1:0] valid_q;
    tag_t tag_q [LINES];
    word_t data_q [LINES][`LINE_WORDS];

    index_t idx;
    tag_t tag;
    logic [WORD_BITS-1:0] word_sel;
    logic hit;
    logic is_store;
    logic beat_done;

    assign idx = addr_q[TAG_LSB-1:OFFSET_BITS];
    assign tag = addr_q[31:TAG_LSB];
    assign word_sel = addr_q[OFFSET_BITS-1:2];
    assign hit = valid_q[idx] && (tag_q[idx] == tag);
    assign is_store = |strobe_q;
    assign beat_done = mem.valid && mem.ready;

    // read hit answers straight from lookup
    assign req.addr_ok = state_q == CACHE_IDLE;
    assign req.data_ok = (state_q == CACHE_LOOKUP && hit && !is_store)
                      || state_q == CACHE_RESPOND;
    assign req.rdata = data_q[idx][word_sel];

    assign mem.valid = state_q == CACHE_REFILL || state_q == CACHE_WRITE_BUS;
    assign mem.is_write = state_q == CACHE_WRITE_BUS;
    assign mem.addr = (state_q == CACHE_REFILL) ? {addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}}
                                                : {addr_q[31:2], 2'b00};
    assign mem.len = (state_q == CACHE_REFILL) ? burst_len_t'(`LINE_WORDS - 1) : '0;
    assign mem.wdata = wdata_q;
    assign mem.strobe = strobe_q;

    always_ff @(posedge clk) begin
        if (req.valid && req.addr_ok) begin
            addr_q <= req.addr;
            strobe_q <= req.strobe;
            wdata_q <= req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= CACHE_IDLE;
            valid_q <= '0;
            beat_q <= '0;
        end else begin
            case (state_q)
                CACHE_IDLE: begin
                    if (req.valid) begin
                        state_q <= CACHE_LOOKUP;
                    end
                end
                CACHE_LOOKUP: begin
                    if (is_store) begin
                        state_q <= CACHE_WRITE_BUS;
                        // without write-through the stale line is dropped
                        if (hit && !WRITE_THROUGH) begin
                            valid_q[idx] <= 1'b0;
                        end
                    end else if (hit) begin
                        state_q <= CACHE_IDLE;
                    end else begin
                        state_q <= CACHE_REFILL;
                        beat_q <= '0;
                    end
                end
                CACHE_REFILL: begin
                    if (beat_done) begin
                        beat_q <= beat_q + 1'b1;
                        if (mem.last) begin
                            valid_q[idx] <= 1'b1;
                            state_q <= CACHE_RESPOND;
                        end
                    end
                end
                CACHE_WRITE_BUS: begin
                    if (beat_done && mem.last) begin
                        state_q <= CACHE_RESPOND;
                    end
                end
                default: state_q <= CACHE_IDLE;
            endcase
        end
    end

    // line fill and store merge, no allocation on write miss
    always_ff @(posedge clk) begin
        if (state_q == CACHE_REFILL && beat_done) begin
            data_q[idx][beat_q] <= mem.rdata;
            if (mem.last) begin
                tag_q[idx] <= tag;
            end
        end else if (state_q == CACHE_LOOKUP && is_store && hit && WRITE_THROUGH) begin
            for (int b = 0; b < 4; b++) begin
                if (strobe_q[b]) begin
                    data_q[idx][word_sel][b*8 +: 8] <= wdata_q[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
        end else if (req.valid && req.addr_ok) begin
            pending_q <= 1'b1;
        end else if (req.data_ok) begin
            pending_q <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        mem.valid && !mem.ready |=> mem.valid
            && $stable({mem.is_write, mem.addr, mem.len, mem.wdata, mem.strobe}));

    assert property (@(posedge clk) disable iff (rst) req.data_ok |-> pending_q);

endmodule

/* uncached_bridge.sv */
`timescale 1ns/1ps

module uncached_bridge import mem_pkg::*; (
    input logic clk,
    input logic rst,
    dbus_if.slave req,
    cbus_if.master mem
);

    bridge_state_t state_q;
    addr_t addr_q;
    strobe_t strobe_q;
    word_t wdata_q;
    word_t rdata_q;

    assign req.addr_ok = state_q == BRIDGE_IDLE;
    assign req.data_ok = state_q == BRIDGE_RESPOND;
    assign req.rdata = rdata_q;

    // always a single beat
    assign mem.valid = state_q == BRIDGE_BUS;
    assign mem.is_write = |strobe_q;
    assign mem.addr = {addr_q[31:2], 2'b00};
    assign mem.len = '0;
    assign mem.wdata = wdata_q;
    assign mem.strobe = strobe_q;

    always_ff @(posedge clk) begin
        if (req.valid && req.addr_ok) begin
            addr_q <= req.addr;
            strobe_q <= req.strobe;
            wdata_q <= req.wdata;
        end
        if (mem.valid && mem.ready && mem.last) begin
            rdata_q <= mem.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= BRIDGE_IDLE;
        end else begin
            case (state_q)
                BRIDGE_IDLE: begin
                    if (req.valid) begin
                        state_q <= BRIDGE_BUS;
                    end
                end
                BRIDGE_BUS: begin
                    if (mem.ready && mem.last) begin
                        state_q <= BRIDGE_RESPOND;
                    end
                end
                default: state_q <= BRIDGE_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) mem.valid |-> mem.len == '0);

endmodule

/* cbus_arbiter.sv */
`timescale 1ns/1ps

module cbus_arbiter (
    input logic clk,
    input logic rst,
    cbus_if.slave m0,
    cbus_if.slave m1,
    cbus_if.slave m2,
    cbus_if.slave m3,
    cbus_if.master bus
);

    logic [3:0] req_valid;
    logic [1:0] pick;
    logic [1:0] grant_q;
    logic busy_q;
    logic [1:0] sel;
    logic [3:0] gnt_oh;

    assign req_valid = {m3.valid, m2.valid, m1.valid, m0.valid};

    // m0 highest
    always_comb begin
        casez (req_valid)
            4'b???1: pick = 2'd0;
            4'b??10: pick = 2'd1;
            4'b?100: pick = 2'd2;
            default: pick = 2'd3;
        endcase
    end

    assign sel = busy_q ? grant_q : pick;
    assign gnt_oh = (busy_q || (|req_valid)) ? (4'b0001 << sel) : 4'b0000;

    always_comb begin
        case (sel)
            2'd0: begin
                bus.valid = m0.valid;
                bus.is_write = m0.is_write;
                bus.addr = m0.addr;
                bus.len = m0.len;
                bus.wdata = m0.wdata;
                bus.strobe = m0.strobe;
            end
            2'd1: begin
                bus.valid = m1.valid;
                bus.is_write = m1.is_write;
                bus.addr = m1.addr;
                bus.len = m1.len;
                bus.wdata = m1.wdata;
                bus.strobe = m1.strobe;
            end
            2'd2: begin
                bus.valid = m2.valid;
                bus.is_write = m2.is_write;
                bus.addr = m2.addr;
                bus.len = m2.len;
                bus.wdata = m2.wdata;
                bus.strobe = m2.strobe;
            end
            default: begin
                bus.valid = m3.valid;
                bus.is_write = m3.is_write;
                bus.addr = m3.addr;
                bus.len = m3.len;
                bus.wdata = m3.wdata;
                bus.strobe = m3.strobe;
            end
        endcase
    end

    assign m0.ready = bus.ready && gnt_oh[0];
    assign m1.ready = bus.ready && gnt_oh[1];
    assign m2.ready = bus.ready && gnt_oh[2];
    assign m3.ready = bus.ready && gnt_oh[3];
    assign m0.last = bus.last && gnt_oh[0];
    assign m1.last = bus.last && gnt_oh[1];
    assign m2.last = bus.last && gnt_oh[2];
    assign m3.last = bus.last && gnt_oh[3];
    assign m0.rdata = gnt_oh[0] ? bus.rdata : '0;
    assign m1.rdata = gnt_oh[1] ? bus.rdata : '0;
    assign m2.rdata = gnt_oh[2] ? bus.rdata : '0;
    assign m3.rdata = gnt_oh[3] ? bus.rdata : '0;

    // lock until last, a single beat that ends at once never locks
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            grant_q <= '0;
        end else if (busy_q) begin
            if (bus.ready && bus.last) begin
                busy_q <= 1'b0;
            end
        end else if (bus.valid) begin
            busy_q <= !(bus.ready && bus.last);
            grant_q <= pick;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        bus.valid && !(bus.ready && bus.last) |=> sel == $past(sel));

endmodule

/* cache_manage.sv */
`timescale 1ns/1ps

module cache_manage import mem_pkg::*; (
    input logic clk,
    input logic rst,

    input logic ireq_valid,
    input addr_t ireq_addr,
    output logic iresp_addr_ok,
    output logic iresp_data_ok,
    output word_t iresp_data,

    input logic dreq1_valid,
    input addr_t dreq1_addr,
    input strobe_t dreq1_strobe,
    input word_t dreq1_wdata,
    output logic dresp1_addr_ok,
    output logic dresp1_data_ok,
    output word_t dresp1_data,

    input logic dreq2_valid,
    input addr_t dreq2_addr,
    input strobe_t dreq2_strobe,
    input word_t dreq2_wdata,
    output logic dresp2_addr_ok,
    output logic dresp2_data_ok,
    output word_t dresp2_data,

    output logic creq_valid,
    output logic creq_is_write,
    output addr_t creq_addr,
    output burst_len_t creq_len,
    output word_t creq_wdata,
    output strobe_t creq_strobe,
    input logic cresp_ready,
    input logic cresp_last,
    input word_t cresp_data
);

    addr_t i_paddr;
    addr_t d1_paddr;
    addr_t d2_paddr;
    logic d1_uncached;
    logic d2_uncached;
    logic d1_cached;
    logic d2_cached;
    logic dc_take_p2;
    logic pend1_q;
    logic pend2_q;
    // data cache request came from port 2
    logic owner_q;

    dbus_if ibus ();
    dbus_if dc_req ();
    dbus_if ub1_req ();
    dbus_if ub2_req ();
    cbus_if ic_mem ();
    cbus_if dc_mem ();
    cbus_if ub1_mem ();
    cbus_if ub2_mem ();
    cbus_if ext_bus ();

    // instruction fetches always go through the icache
    addr_translate i_itrans (.vaddr(ireq_addr), .paddr(i_paddr), .uncached());
    addr_translate i_d1trans (.vaddr(dreq1_addr), .paddr(d1_paddr), .uncached(d1_uncached));
    addr_translate i_d2trans (.vaddr(dreq2_addr), .paddr(d2_paddr), .uncached(d2_uncached));

    assign ibus.valid = ireq_valid;
    assign ibus.addr = i_paddr;
    assign ibus.strobe = '0;
    assign ibus.wdata = '0;
    assign iresp_addr_ok = ibus.addr_ok;
    assign iresp_data_ok = ibus.data_ok;
    assign iresp_data = ibus.rdata;

    // port 1 wins the shared dcache
    assign d1_cached = dreq1_valid && !pend1_q && !d1_uncached;
    assign d2_cached = dreq2_valid && !pend2_q && !d2_uncached;
    assign dc_take_p2 = d2_cached && !d1_cached;

    assign dc_req.valid = d1_cached || d2_cached;
    assign dc_req.addr = dc_take_p2 ? d2_paddr : d1_paddr;
    assign dc_req.strobe = dc_take_p2 ? dreq2_strobe : dreq1_strobe;
    assign dc_req.wdata = dc_take_p2 ? dreq2_wdata : dreq1_wdata;

    assign ub1_req.valid = dreq1_valid && !pend1_q && d1_uncached;
    assign ub1_req.addr = d1_paddr;
    assign ub1_req.strobe = dreq1_strobe;
    assign ub1_req.wdata = dreq1_wdata;

    assign ub2_req.valid = dreq2_valid && !pend2_q && d2_uncached;
    assign ub2_req.addr = d2_paddr;
    assign ub2_req.strobe = dreq2_strobe;
    assign ub2_req.wdata = dreq2_wdata;

    assign dresp1_addr_ok = !pend1_q && (d1_uncached ? ub1_req.addr_ok : dc_req.addr_ok);
    assign dresp2_addr_ok = !pend2_q
                         && (d2_uncached ? ub2_req.addr_ok : dc_req.addr_ok && !d1_cached);

    assign dresp1_data_ok = ub1_req.data_ok || (dc_req.data_ok && !owner_q);
    assign dresp1_data = ub1_req.data_ok ? ub1_req.rdata : dc_req.rdata;
    assign dresp2_data_ok = ub2_req.data_ok || (dc_req.data_ok && owner_q);
    assign dresp2_data = ub2_req.data_ok ? ub2_req.rdata : dc_req.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend1_q <= 1'b0;
            pend2_q <= 1'b0;
            owner_q <= 1'b0;
        end else begin
            pend1_q <= (dreq1_valid && dresp1_addr_ok) || (pend1_q && !dresp1_data_ok);
            pend2_q <= (dreq2_valid && dresp2_addr_ok) || (pend2_q && !dresp2_data_ok);
            if (dc_req.valid && dc_req.addr_ok) begin
                owner_q <= dc_take_p2;
            end
        end
    end

    line_cache #(.WRITE_THROUGH(1'b0)) i_icache (.clk, .rst, .req(ibus), .mem(ic_mem));
    line_cache #(.WRITE_THROUGH(1'b1)) i_dcache (.clk, .rst, .req(dc_req), .mem(dc_mem));
    uncached_bridge i_bridge1 (.clk, .rst, .req(ub1_req), .mem(ub1_mem));
    uncached_bridge i_bridge2 (.clk, .rst, .req(ub2_req), .mem(ub2_mem));

    cbus_arbiter i_arbiter (
        .clk,
        .rst,
        .m0(ub1_mem),
        .m1(dc_mem),
        .m2(ub2_mem),
        .m3(ic_mem),
        .bus(ext_bus)
    );

    assign creq_valid = ext_bus.valid;
    assign creq_is_write = ext_bus.is_write;
    assign creq_addr = ext_bus.addr;
    assign creq_len = ext_bus.len;
    assign creq_wdata = ext_bus.wdata;
    assign creq_strobe = ext_bus.strobe;
    assign ext_bus.ready = cresp_ready;
    assign ext_bus.last = cresp_last;
    assign ext_bus.rdata = cresp_data;

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps
`include "mem_defines.svh"

module tb_checker import mem_pkg::*; (
    input logic clk,
    input logic rst,
    input logic ireq_valid,
    input addr_t ireq_addr,
    input logic iresp_addr_ok,
    input logic iresp_data_ok,
    input word_t iresp_data,
    input logic dreq1_valid,
    input addr_t dreq1_addr,
    input strobe_t dreq1_strobe,
    input word_t dreq1_wdata,
    input logic dresp1_addr_ok,
    input logic dresp1_data_ok,
    input word_t dresp1_data,
    input logic dreq2_valid,
    input addr_t dreq2_addr,
    input strobe_t dreq2_strobe,
    input word_t dreq2_wdata,
    input logic dresp2_addr_ok,
    input logic dresp2_data_ok,
    input word_t dresp2_data,
    input logic creq_valid,
    input logic creq_is_write,
    input addr_t creq_addr,
    input burst_len_t creq_len,
    input word_t creq_wdata,
    input strobe_t creq_strobe,
    input logic cresp_ready,
    input logic cresp_last,
    input logic case_active,
    input logic [7:0] case_num,
    input logic [3:0] case_op,
    output int errors
);

    word_t mem [addr_t];
    logic [15:0] ic_v;
    logic [15:0] dc_v;
    logic [23:0] ic_tag [16];
    logic [23:0] dc_tag [16];
    word_t exp_i;
    word_t exp_d1;
    word_t exp_d2;
    logic rd1;
    logic rd2;
    // {is_write, len, addr, strobe, wdata}
    logic [72:0] exp_txn [$];
    logic [72:0] cur_txn;
    logic in_txn;
    logic rst_q;
    logic active_q;
    int case_errs;
    time t1;
    time t2;

    initial begin
        errors = 0;
        case_errs = 0;
        ic_v = '0;
        dc_v = '0;
        in_txn = 1'b0;
        rd1 = 1'b0;
        rd2 = 1'b0;
    end

    function automatic addr_t phys(input addr_t v);
        addr_t seg;
        seg = v & `SEG_MASK;
        return (seg == `KSEG0_BASE || seg == `KSEG1_BASE) ? (v & ~`SEG_MASK) : v;
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a_0000);
    endfunction

    task automatic fail(input string msg);
        $display("%s", msg);
        errors++;
        case_errs++;
    endtask

    task automatic compare(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic fetch(input addr_t v);
        addr_t p;
        p = phys(v);
        if (!(ic_v[p[7:4]] && ic_tag[p[7:4]] == p[31:8])) begin
            exp_txn.push_back({1'b0, 4'd3, p[31:4], 4'h0, 4'h0, 32'h0});
            ic_v[p[7:4]] = 1'b1;
            ic_tag[p[7:4]] = p[31:8];
        end
        exp_i = mem_word({p[31:2], 2'b00});
    endtask

    task automatic data_request(input int port, input addr_t v, input strobe_t s,
                                input word_t w);
        addr_t p;
        word_t m;
        p = phys(v) & 32'hffff_fffc;
        if (s != 0) begin
            // stores never allocate in the dcache
            exp_txn.push_back({1'b1, 4'd0, p, s, w});
            m = mem_word(p);
            for (int b = 0; b < 4; b++) begin
                if (s[b]) begin
                    m[b*8 +: 8] = w[b*8 +: 8];
                end
            end
            mem[p] = m;
        end else if ((v & `SEG_MASK) == `KSEG1_BASE) begin
            exp_txn.push_back({1'b0, 4'd0, p, 4'h0, 32'h0});
        end else if (!(dc_v[p[7:4]] && dc_tag[p[7:4]] == p[31:8])) begin
            exp_txn.push_back({1'b0, 4'd3, p[31:4], 4'h0, 4'h0, 32'h0});
            dc_v[p[7:4]] = 1'b1;
            dc_tag[p[7:4]] = p[31:8];
        end
        if (port == 1) begin
            rd1 = s == 0;
            exp_d1 = mem_word(p);
        end else begin
            rd2 = s == 0;
            exp_d2 = mem_word(p);
        end
    endtask

    task automatic match_txn(input logic [72:0] t);
        int idx [$];
        idx = exp_txn.find_first_index(x) with (x == t);
        if (idx.size() == 0) begin
            fail($sformatf({"unexpected cbus transaction at %0t: write %b len %0d addr %h",
                            " strobe %h data %h"},
                           $time, t[72], t[71:68], t[67:36], t[35:32], t[31:0]));
        end else begin
            exp_txn.delete(idx[0]);
        end
    endtask

    always @(posedge clk) begin
        if (rst || rst_q) begin
            if (creq_valid || iresp_data_ok || dresp1_data_ok || dresp2_data_ok) begin
                fail($sformatf("cbus valid or data_ok high around reset at %0t", $time));
            end
        end
        rst_q <= rst;
        if (case_active && !active_q) begin
            case_errs = 0;
            t1 = 0;
            t2 = 0;
            exp_txn.delete();
        end
        if (!rst) begin
            if (ireq_valid && iresp_addr_ok) fetch(ireq_addr);
            if (dreq1_valid && dresp1_addr_ok) begin
                data_request(1, dreq1_addr, dreq1_strobe, dreq1_wdata);
            end
            if (dreq2_valid && dresp2_addr_ok) begin
                data_request(2, dreq2_addr, dreq2_strobe, dreq2_wdata);
            end
            if (iresp_data_ok) compare("iresp_data", iresp_data, exp_i);
            if (dresp1_data_ok) begin
                t1 = $time;
                if (rd1) compare("dresp1_data", dresp1_data, exp_d1);
            end
            if (dresp2_data_ok) begin
                t2 = $time;
                if (rd2) compare("dresp2_data", dresp2_data, exp_d2);
            end
            if (creq_valid) begin
                if (in_txn) begin
                    compare("creq_addr", creq_addr, cur_txn[67:36]);
                    compare("creq_len", word_t'(creq_len), word_t'(cur_txn[71:68]));
                    compare("creq_is_write", word_t'(creq_is_write), word_t'(cur_txn[72]));
                end else begin
                    cur_txn = {creq_is_write, creq_len, creq_addr,
                               creq_is_write ? creq_strobe : 4'h0,
                               creq_is_write ? creq_wdata : 32'h0};
                    match_txn(cur_txn);
                end
                in_txn = !(cresp_ready && cresp_last);
            end
        end
        if (!case_active && active_q) begin
            if (exp_txn.size() != 0) begin
                fail($sformatf("%0d expected cbus transactions never appeared", exp_txn.size()));
            end
            if (case_op == 4'd1 && t2 < t1) begin
                fail("port 2 got data_ok before port 1");
            end
            $display("case %0d op %0d: %s", case_num, case_op, case_errs == 0 ? "ok" : "FAILED");
        end
        active_q <= case_active;
    end

endmodule

/* tb_cache_manage.sv */
`timescale 1ns/1ps

module tb_cache_manage import mem_pkg::*; ();

    localparam int TIMEOUT = 500;
    localparam int MAX_CASES = 32;

    logic clk;
    logic rst;
    logic ireq_valid;
    addr_t ireq_addr;
    logic iresp_addr_ok;
    logic iresp_data_ok;
    word_t iresp_data;
    logic dreq1_valid;
    addr_t dreq1_addr;
    strobe_t dreq1_strobe;
    word_t dreq1_wdata;
    logic dresp1_addr_ok;
    logic dresp1_data_ok;
    word_t dresp1_data;
    logic dreq2_valid;
    addr_t dreq2_addr;
    strobe_t dreq2_strobe;
    word_t dreq2_wdata;
    logic dresp2_addr_ok;
    logic dresp2_data_ok;
    word_t dresp2_data;
    logic creq_valid;
    logic creq_is_write;
    addr_t creq_addr;
    burst_len_t creq_len;
    word_t creq_wdata;
    strobe_t creq_strobe;
    logic cresp_ready;
    logic cresp_last;
    word_t cresp_data;

    logic case_active;
    logic [7:0] case_num;
    logic [3:0] case_op;
    int errors;
    logic timed_out;
    int n_cases;

    // op, port, vaddr, wdata, strobe
    logic [75:0] cases [MAX_CASES];
    word_t mem [addr_t];
    burst_len_t beat;

    cache_manage i_cache_manage (.*);

    tb_checker i_checker (.*);

    always #50 clk = ~clk;

    function automatic word_t mem_read(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    // cbus slave, one idle cycle between transactions, random stalls
    always @(posedge clk) begin
        burst_len_t next_beat;
        addr_t a;
        word_t w;
        if (rst) begin
            cresp_ready <= 1'b0;
            cresp_last <= 1'b0;
            cresp_data <= '0;
            beat <= '0;
        end else begin
            next_beat = beat;
            if (creq_valid && cresp_ready) begin
                if (creq_is_write) begin
                    a = creq_addr + {beat, 2'b00};
                    w = mem_read(a);
                    for (int b = 0; b < 4; b++) begin
                        if (creq_strobe[b]) begin
                            w[b*8 +: 8] = creq_wdata[b*8 +: 8];
                        end
                    end
                    mem[a] = w;
                end
                next_beat = cresp_last ? '0 : beat + 1'b1;
            end
            beat <= next_beat;
            if (creq_valid && !(cresp_ready && cresp_last) && ($urandom % 4 != 0)) begin
                cresp_ready <= 1'b1;
                cresp_last <= next_beat == creq_len;
                cresp_data <= mem_read(creq_addr + {next_beat, 2'b00});
            end else begin
                cresp_ready <= 1'b0;
                cresp_last <= 1'b0;
            end
        end
    end

    task automatic set_request(input int port, input logic v, input addr_t a,
                               input strobe_t s, input word_t w);
        case (port)
            0: begin
                ireq_valid <= v;
                ireq_addr <= a;
            end
            1: begin
                dreq1_valid <= v;
                dreq1_addr <= a;
                dreq1_strobe <= s;
                dreq1_wdata <= w;
            end
            default: begin
                dreq2_valid <= v;
                dreq2_addr <= a;
                dreq2_strobe <= s;
                dreq2_wdata <= w;
            end
        endcase
    endtask

    function automatic logic port_addr_ok(input int port);
        return port == 0 ? iresp_addr_ok : port == 1 ? dresp1_addr_ok : dresp2_addr_ok;
    endfunction

    function automatic logic port_data_ok(input int port);
        return port == 0 ? iresp_data_ok : port == 1 ? dresp1_data_ok : dresp2_data_ok;
    endfunction

    task automatic access(input int port, input addr_t addr, input strobe_t strb,
                          input word_t wdata);
        int n;
        logic seen;
        @(posedge clk);
        set_request(port, 1'b1, addr, strb, wdata);
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            seen = port_addr_ok(port);
            n++;
        end
        @(posedge clk);
        set_request(port, 1'b0, '0, '0, '0);
        if (!seen) begin
            $display("port %0d request to %h was never accepted", port, addr);
            timed_out = 1'b1;
        end else begin
            n = 0;
            seen = 1'b0;
            while (!seen && n < TIMEOUT) begin
                @(negedge clk);
                seen = port_data_ok(port);
                n++;
            end
            if (!seen) begin
                $display("port %0d request to %h never got data_ok", port, addr);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        int i;
        logic [75:0] c;
        addr_t ua;
        clk = 1'b0;
        rst = 1'b1;
        cresp_ready = 1'b0;
        cresp_last = 1'b0;
        cresp_data = '0;
        set_request(0, 1'b0, '0, '0, '0);
        set_request(1, 1'b0, '0, '0, '0);
        set_request(2, 1'b0, '0, '0, '0);
        case_active = 1'b0;
        case_num = '0;
        case_op = '0;
        timed_out = 1'b0;
        n_cases = 0;
        void'($urandom(32'h6efc_5397));
        for (i = 0; i < MAX_CASES; i++) begin
            cases[i] = '1;
        end
        $readmemh("cache_cases.txt", cases);
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        i = 0;
        while (i < MAX_CASES && cases[i][75:72] != 4'hf && !timed_out) begin
            c = cases[i];
            @(posedge clk);
            case_active <= 1'b1;
            case_num <= 8'(i);
            case_op <= c[75:72];
            case (c[75:72])
                4'd0: access(c[71:68], c[67:36], c[3:0], c[35:4]);
                4'd1: begin
                    // same cycle on both data ports, different lines
                    fork
                        access(1, c[67:36], '0, '0);
                        access(2, c[67:36] + 32'h40, '0, '0);
                    join
                end
                default: begin
                    ua = (c[67:36] & 32'h1fff_ffff) | 32'ha000_0000;
                    fork
                        access(0, c[67:36], '0, '0);
                        access(1, ua, '0, '0);
                    join
                end
            endcase
            @(posedge clk);
            case_active <= 1'b0;
            @(posedge clk);
            i++;
            n_cases++;
        end
        repeat (2) @(posedge clk);
        $display("%0d cases run, %0d errors", n_cases, errors);
        if (timed_out || errors != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

/* cache_cases.txt */
// op_port_vaddr_wdata_strobe, op 0 single access, 1 dual data read, 2 fetch with uncached read
// port 0 instruction, 1 data port 1, 2 data port 2, strobe zero is a read
0_0_80000100_00000000_0
0_0_80000108_00000000_0
0_1_A0000400_00000000_0
0_1_A0000400_00000000_0
0_2_A0000404_CAFEF00D_F
0_1_A0000404_00000000_0
0_1_80000300_00000000_0
0_1_80000304_11223344_6
0_1_80000304_00000000_0
0_2_00001310_00000000_0
1_1_80000500_00000000_0
1_1_80000504_00000000_0
2_0_80000600_00000000_0
2_0_80000710_00000000_0

/* sim.f */
+incdir+.
mem_pkg.sv
bus_if.sv
addr_translate.sv
line_cache.sv
uncached_bridge.sv
cbus_arbiter.sv
cache_manage.sv
tb_checker.sv
tb_cache_manage.sv

/* Bender.yml */
package:
  name: cache_manage

sources:
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - bus_if.sv
      - addr_translate.sv
      - line_cache.sv
      - uncached_bridge.sv
      - cbus_arbiter.sv
      - cache_manage.sv
      - target: test
        files:
          - tb_checker.sv
          - tb_cache_manage.sv
